/* include/master_sync_defines.svh */
`ifndef MASTER_SYNC_DEFINES_SVH
`define MASTER_SYNC_DEFINES_SVH

// Remote nodes served by the master
`define MS_NODES 4
`define MS_NODE_W 2

// Receive buffer address map
`define MS_PTR_W 8
`define MS_MSG_LEN 16
`define MS_HIPRI_BASE 32

// Byte offsets inside one mailbox
`define MS_FLAG_OFS 2
`define MS_TS_OFS 4

`define MS_TS_WORDS 4 // Timestamp words per node

`endif

/* design/master_sync_pkg.sv */
`include "master_sync_defines.svh"

package master_sync_pkg;

	localparam int TS_WORD_W = $clog2(`MS_TS_WORDS);

	typedef struct packed {
		logic [`MS_PTR_W-1:0] addr;
		logic [7:0]           data;
		logic                 we;
	} rx_write_t;

	// Local transmit/receive counter captures
	typedef struct packed {
		logic [15:0] rx2;
		logic [15:0] tx2;
		logic [15:0] rx1;
		logic [15:0] tx1;
	} snapshot_t;

	typedef struct packed {
		logic [`MS_NODE_W-1:0] node;
		logic [TS_WORD_W-1:0]  word;
	} ts_index_t;

	typedef struct packed {
		logic       bank; // High byte bank when set
		ts_index_t  index;
		logic [7:0] data;
		logic       we;
	} ts_write_t;

	typedef logic [`MS_NODES-1:0] node_mask_t;

	typedef struct packed {
		node_mask_t rx_ok;
		node_mask_t sync_ok;
		node_mask_t slave_rdy;
		node_mask_t scope_trigger;
	} node_status_t;

	typedef struct packed {
		logic [15:0] delay;
		logic [15:0] offset;
	} node_result_t;

	typedef node_result_t [`MS_NODES-1:0] result_array_t;

endpackage

/* design/mailbox_decode.sv */
`timescale 1ns/1ps
`include "master_sync_defines.svh"

module mailbox_decode (
	input  logic                        clk_i,
	input  logic                        rst_i,
	input  master_sync_pkg::rx_write_t  rx_write_i,
	input  logic                        cycle_start_i,
	output master_sync_pkg::ts_write_t  ts_wr_o,
	output logic [`MS_NODES-1:0][15:0]  flags_o,
	output master_sync_pkg::node_mask_t rdy_lo_o,
	output master_sync_pkg::node_mask_t rdy_hi_o
);
	localparam int PTR_W = `MS_PTR_W;

	master_sync_pkg::node_mask_t rdy_lo_nxt;
	master_sync_pkg::node_mask_t rdy_hi_nxt;
	master_sync_pkg::node_mask_t prev_ok;
	master_sync_pkg::node_mask_t flag_lo_we;
	master_sync_pkg::node_mask_t flag_hi_we;

	// Node 0 is always allowed, node i waits for a full set from node i-1
	assign prev_ok = {rdy_lo_o[`MS_NODES-2:0] & rdy_hi_o[`MS_NODES-2:0], 1'b1};

	always_comb begin
		ts_wr_o = '0;
		ts_wr_o.data = rx_write_i.data;
		rdy_lo_nxt = rdy_lo_o;
		rdy_hi_nxt = rdy_hi_o;
		flag_lo_we = '0;
		flag_hi_we = '0;
		for (int n = 0; n < `MS_NODES; n++) begin
			if (rx_write_i.addr == PTR_W'(`MS_HIPRI_BASE + n*`MS_MSG_LEN + `MS_FLAG_OFS))
				flag_lo_we[n] = rx_write_i.we;
			if (rx_write_i.addr == PTR_W'(`MS_HIPRI_BASE + n*`MS_MSG_LEN + `MS_FLAG_OFS + 1))
				flag_hi_we[n] = rx_write_i.we;

			for (int k = 0; k < `MS_TS_WORDS; k++) begin
				// Low byte of word k
				if (rx_write_i.addr == PTR_W'(`MS_HIPRI_BASE + n*`MS_MSG_LEN + `MS_TS_OFS + 2*k)) begin
					ts_wr_o.we = rx_write_i.we;
					ts_wr_o.bank = 1'b0;
					ts_wr_o.index.node = n[`MS_NODE_W-1:0];
					ts_wr_o.index.word = k[master_sync_pkg::TS_WORD_W-1:0];
					if (rx_write_i.we && prev_ok[n])
						rdy_lo_nxt[n] = 1'b1;
				end
				// High byte, only after the low byte was seen
				if (rx_write_i.addr ==
						PTR_W'(`MS_HIPRI_BASE + n*`MS_MSG_LEN + `MS_TS_OFS + 2*k + 1)) begin
					ts_wr_o.we = rx_write_i.we;
					ts_wr_o.bank = 1'b1;
					ts_wr_o.index.node = n[`MS_NODE_W-1:0];
					ts_wr_o.index.word = k[master_sync_pkg::TS_WORD_W-1:0];
					if (rx_write_i.we && prev_ok[n] && rdy_lo_o[n])
						rdy_hi_nxt[n] = 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i || cycle_start_i) begin // Cycle start beats a write
			rdy_lo_o <= '0;
			rdy_hi_o <= '0;
			flags_o <= '0;
		end else begin
			rdy_lo_o <= rdy_lo_nxt;
			rdy_hi_o <= rdy_hi_nxt;
			for (int n = 0; n < `MS_NODES; n++) begin
				if (flag_lo_we[n])
					flags_o[n][7:0] <= rx_write_i.data;
				if (flag_hi_we[n])
					flags_o[n][15:8] <= rx_write_i.data;
			end
		end
	end

endmodule

/* design/timestamp_ram.sv */
`timescale 1ns/1ps
`include "master_sync_defines.svh"

module timestamp_ram (
	input  logic                       clk_i,
	input  logic                       rst_i,
	input  master_sync_pkg::ts_write_t ts_wr_i,
	input  master_sync_pkg::ts_index_t rd_index_i,
	output logic [15:0]                rd_data_o
);
	localparam int DEPTH = `MS_NODES * `MS_TS_WORDS;

	logic [7:0] bank_lo [DEPTH];
	logic [7:0] bank_hi [DEPTH];

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			for (int i = 0; i < DEPTH; i++) begin
				bank_lo[i] <= '0;
				bank_hi[i] <= '0;
			end
		end else if (ts_wr_i.we) begin
			if (ts_wr_i.bank)
				bank_hi[ts_wr_i.index] <= ts_wr_i.data;
			else
				bank_lo[ts_wr_i.index] <= ts_wr_i.data;
		end
	end

	// Asynchronous read, sequencer uses the word in the same cycle
	assign rd_data_o = {bank_hi[rd_index_i], bank_lo[rd_index_i]};

endmodule

/* design/offset_execute.sv */
`timescale 1ns/1ps
`include "master_sync_defines.svh"

module offset_execute (
	input  logic                          clk_i,
	input  logic                          rst_i,
	input  logic                          cycle_pulse_i,
	input  master_sync_pkg::snapshot_t    snapshot_i,
	input  logic [15:0]                   rd_data_i,
	output master_sync_pkg::ts_index_t    rd_index_o,
	output logic                          cycle_start_o,
	output logic                          res_we_o,
	output logic [`MS_NODE_W-1:0]         res_node_o,
	output master_sync_pkg::node_result_t res_o,
	output logic                          seq_done_o
);
	localparam int WORD_W = master_sync_pkg::TS_WORD_W;
	localparam logic [`MS_NODE_W-1:0] LAST_NODE = `MS_NODE_W'(`MS_NODES - 1);

	typedef enum logic [2:0] {
		S_IDLE,
		S_W0, // Own word 0
		S_W1, // Own word 1
		S_P2, // Previous node word 2 or tx1
		S_P3, // Previous node word 3 or rx1
		S_STORE
	} state_t;

	state_t                     state_q;
	logic [`MS_NODE_W-1:0]      node_q;
	master_sync_pkg::snapshot_t snap_q;
	logic [15:0]                acc_delay;
	logic [15:0]                acc_offset;
	logic [15:0]                operand;

	assign cycle_start_o = cycle_pulse_i && (state_q == S_IDLE);
	assign res_we_o = (state_q == S_STORE);
	assign res_node_o = node_q;
	assign res_o = {acc_delay, acc_offset};
	assign seq_done_o = res_we_o && (node_q == LAST_NODE);

	always_comb begin
		rd_index_o.node = node_q;
		rd_index_o.word = '0;
		case (state_q)
			S_W1: rd_index_o.word = WORD_W'(1);
			S_P2: begin
				rd_index_o.node = node_q - 1'b1;
				rd_index_o.word = WORD_W'(2);
			end
			S_P3: begin
				rd_index_o.node = node_q - 1'b1;
				rd_index_o.word = WORD_W'(3);
			end
			default: ;
		endcase
	end

	// Node 0 has no neighbour, it pairs with the local snapshot
	always_comb begin
		operand = rd_data_i;
		if (node_q == '0) begin
			if (state_q == S_P2)
				operand = snap_q.tx1;
			else if (state_q == S_P3)
				operand = snap_q.rx1;
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_q <= S_IDLE;
			node_q <= '0;
		end else begin
			case (state_q)
				S_IDLE: begin
					node_q <= '0;
					if (cycle_pulse_i)
						state_q <= S_W0;
				end
				S_W0: state_q <= S_W1;
				S_W1: state_q <= S_P2;
				S_P2: state_q <= S_P3;
				S_P3: state_q <= S_STORE;
				S_STORE: begin
					node_q <= node_q + 1'b1;
					state_q <= (node_q == LAST_NODE) ? S_IDLE : S_W0;
				end
				default: state_q <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (cycle_start_o)
			snap_q <= snapshot_i;
		case (state_q)
			S_W0: begin
				acc_delay <= acc_delay + operand;
				acc_offset <= acc_offset + operand;
			end
			S_W1: begin
				acc_delay <= acc_delay - operand;
				acc_offset <= acc_offset + operand;
			end
			S_P2: begin
				acc_delay <= acc_delay - operand;
				acc_offset <= acc_offset - operand;
			end
			S_P3: begin
				acc_delay <= acc_delay + operand;
				acc_offset <= acc_offset - operand;
			end
			default: begin // Idle and store start the next node from zero
				acc_delay <= '0;
				acc_offset <= '0;
			end
		endcase
	end

endmodule

/* design/sync_result.sv */
`timescale 1ns/1ps
`include "master_sync_defines.svh"

module sync_result (
	input  logic                          clk_i,
	input  logic                          rst_i,
	input  logic                          cycle_start_i,
	input  logic [`MS_NODES-1:0][15:0]    flags_i,
	input  master_sync_pkg::node_mask_t   rdy_lo_i,
	input  master_sync_pkg::node_mask_t   rdy_hi_i,
	input  logic                          res_we_i,
	input  logic [`MS_NODE_W-1:0]         res_node_i,
	input  master_sync_pkg::node_result_t res_i,
	input  logic                          seq_done_i,
	output master_sync_pkg::node_status_t status_o,
	output master_sync_pkg::result_array_t results_o,
	output logic                          done_o
);
	master_sync_pkg::node_status_t status_nxt;

	always_comb begin
		status_nxt.rx_ok = rdy_lo_i & rdy_hi_i;
		for (int n = 0; n < `MS_NODES; n++) begin
			status_nxt.sync_ok[n] = status_nxt.rx_ok[n] & flags_i[n][0];
			status_nxt.slave_rdy[n] = status_nxt.sync_ok[n] & flags_i[n][1];
			status_nxt.scope_trigger[n] = status_nxt.rx_ok[n] & flags_i[n][2];
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			status_o <= '0;
			results_o <= '0;
			done_o <= 1'b0;
		end else begin
			done_o <= seq_done_i; // One cycle after the last store
			if (cycle_start_i)
				status_o <= status_nxt;
			if (res_we_i)
				results_o[res_node_i] <= res_i;
		end
	end

endmodule

/* design/master_sync.sv */
`timescale 1ns/1ps
`include "master_sync_defines.svh"

module master_sync (
	input  logic                           clk_i,
	input  logic                           rst_i,
	input  master_sync_pkg::rx_write_t     rx_write_i,
	input  logic                           cycle_pulse_i,
	input  master_sync_pkg::snapshot_t     snapshot_i,
	output master_sync_pkg::node_status_t  status_o,
	output master_sync_pkg::result_array_t results_o,
	output logic                           done_o
);
	master_sync_pkg::ts_write_t    ts_wr;
	master_sync_pkg::ts_index_t    rd_index;
	master_sync_pkg::node_mask_t   rdy_lo;
	master_sync_pkg::node_mask_t   rdy_hi;
	master_sync_pkg::node_result_t res;
	logic [`MS_NODES-1:0][15:0]    flags;
	logic [15:0]                   rd_data;
	logic [`MS_NODE_W-1:0]         res_node;
	logic                          cycle_start;
	logic                          res_we;
	logic                          seq_done;

	mailbox_decode mailbox_decode_i (
		.clk_i         (clk_i),
		.rst_i         (rst_i),
		.rx_write_i    (rx_write_i),
		.cycle_start_i (cycle_start),
		.ts_wr_o       (ts_wr),
		.flags_o       (flags),
		.rdy_lo_o      (rdy_lo),
		.rdy_hi_o      (rdy_hi)
	);

	timestamp_ram timestamp_ram_i (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.ts_wr_i    (ts_wr),
		.rd_index_i (rd_index),
		.rd_data_o  (rd_data)
	);

	offset_execute offset_execute_i (
		.clk_i         (clk_i),
		.rst_i         (rst_i),
		.cycle_pulse_i (cycle_pulse_i),
		.snapshot_i    (snapshot_i),
		.rd_data_i     (rd_data),
		.rd_index_o    (rd_index),
		.cycle_start_o (cycle_start),
		.res_we_o      (res_we),
		.res_node_o    (res_node),
		.res_o         (res),
		.seq_done_o    (seq_done)
	);

	sync_result sync_result_i (
		.clk_i         (clk_i),
		.rst_i         (rst_i),
		.cycle_start_i (cycle_start),
		.flags_i       (flags),
		.rdy_lo_i      (rdy_lo),
		.rdy_hi_i      (rdy_hi),
		.res_we_i      (res_we),
		.res_node_i    (res_node),
		.res_i         (res),
		.seq_done_i    (seq_done),
		.status_o      (status_o),
		.results_o     (results_o),
		.done_o        (done_o)
	);

endmodule

/* bench/master_sync_tb.sv */
`timescale 1ns/1ps
`include "master_sync_defines.svh"

module master_sync_tb;

	localparam int REC_WORDS = 6; // Kind plus five fields
	localparam int MAX_REC = 64;
	localparam int DONE_LATENCY = 21;
	localparam int CYCLES_PER_REC = 30;
	localparam int IDLE_CHECK = 25; // Quiet cycles after a busy pulse

	logic                           clk_i;
	logic                           rst_i;
	master_sync_pkg::rx_write_t     rx_write_i;
	logic                           cycle_pulse_i;
	master_sync_pkg::snapshot_t     snapshot_i;
	master_sync_pkg::node_status_t  status_o;
	master_sync_pkg::result_array_t results_o;
	logic                           done_o;

	logic [31:0] stim_mem [REC_WORDS*MAX_REC];
	int          n_rec = 0;

	master_sync master_sync_i (
		.clk_i         (clk_i),
		.rst_i         (rst_i),
		.rx_write_i    (rx_write_i),
		.cycle_pulse_i (cycle_pulse_i),
		.snapshot_i    (snapshot_i),
		.status_o      (status_o),
		.results_o     (results_o),
		.done_o        (done_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #50 clk_i = ~clk_i;
	end

	task automatic check_value(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERR at %0d ns: %s is %h, expected %h", $time, what, got, exp);
			$display("Finished with errors");
			$fatal(1, "Value mismatch");
		end
	endtask

	// One byte per rising edge from addr upward
	task automatic write_bytes(input logic [7:0] addr, input int count,
			input logic [95:0] bytes);
		for (int j = 0; j < count; j++) begin
			if (j > 0)
				@(posedge clk_i);
			rx_write_i <= {addr + 8'(j), bytes[8*j +: 8], 1'b1};
		end
	endtask

	// Busy pulse with a new snapshot busy_gap edges after the accepted one
	task automatic wait_for_done(input int busy_gap);
		int cycles;
		cycles = 0;
		do begin
			@(posedge clk_i);
			cycles++;
			cycle_pulse_i <= (cycles == busy_gap);
			if (cycles == busy_gap)
				snapshot_i <= ~snapshot_i; // Must not reach the running sequence
			@(negedge clk_i);
		end while (!done_o);
		check_value("done latency", 32'(cycles), 32'(DONE_LATENCY));
		@(negedge clk_i);
		check_value("done width", {31'd0, done_o}, 32'd0);
		if (busy_gap != 0) begin
			repeat (IDLE_CHECK) begin
				@(negedge clk_i);
				check_value("done after busy pulse", {31'd0, done_o}, 32'd0);
			end
		end
	endtask

	task automatic compare_outputs(input int base);
		@(negedge clk_i);
		check_value("status", {16'd0, status_o}, stim_mem[base+1]);
		for (int n = 0; n < `MS_NODES; n++)
			check_value($sformatf("node %0d result", n), results_o[n], stim_mem[base+2+n]);
	endtask

	initial begin
		int base;
		rst_i <= 1'b1;
		rx_write_i <= '0;
		cycle_pulse_i <= 1'b0;
		snapshot_i <= '0;

		$readmemh("bench/master_sync_stim.txt", stim_mem);
		while (n_rec < MAX_REC && stim_mem[n_rec*REC_WORDS] != 32'd0)
			n_rec++;
		if (n_rec == 0) begin
			$display("No stimulus records found in bench/master_sync_stim.txt");
			$display("Finished with errors");
			$fatal(1, "Empty stimulus table");
		end

		repeat (4) @(posedge clk_i);
		rst_i <= 1'b0;

		for (int r = 0; r < n_rec; r++) begin
			base = r * REC_WORDS;
			@(posedge clk_i);
			rx_write_i <= '0;
			cycle_pulse_i <= 1'b0;
			case (stim_mem[base])
				32'd1: write_bytes(stim_mem[base+1][7:0], int'(stim_mem[base+2]),
					{stim_mem[base+5], stim_mem[base+4], stim_mem[base+3]});
				32'd2: begin
					snapshot_i <= {stim_mem[base+1], stim_mem[base+2]};
					cycle_pulse_i <= 1'b1;
					wait_for_done(int'(stim_mem[base+3]));
				end
				32'd3: compare_outputs(base);
				default: begin
					$display("Unknown record kind %0h in record %0d", stim_mem[base], r);
					$display("Finished with errors");
					$fatal(1, "Bad stimulus table");
				end
			endcase
		end

		$display("Finished with no errors");
		$finish;
	end

	// Budget grows with the table length
	initial begin
		wait (n_rec > 0);
		repeat (n_rec * CYCLES_PER_REC) @(posedge clk_i);
		$display("Timeout: the run did not finish within %0d cycles", n_rec * CYCLES_PER_REC);
		$display("Finished with errors");
		$fatal(1, "Watchdog expired");
	end

endmodule

/* bench/master_sync_stim.txt */
// kind 1 write: addr count bytes[31:0] bytes[63:32] bytes[95:64], byte 0 lowest
// kind 2 pulse: {rx2,tx2} {rx1,tx1} busy_gap 0 0; kind 3 expect: status res0..res3
// Pulse after reset with no writes
2 11112222 01500100 0 0 0
3 00000000 0050FDB0 00000000 00000000 00000000
// All nodes in order, flags 0007
1 22 A 10000007 20000F80 00001F00
1 32 A 30000007 40002F40 00003E00
1 42 A 50000007 60004FA0 00005D00
1 52 A 70000007 80006F10 00007C00
2 AAAABBBB 0F000E00 0 0 0
3 0000FFFF 01800280 FFC02040 FE6021A0 FDF02210
// Node 1 skipped
1 22 A 01000003 02000040 00000180
1 42 A 05000007 06000480 00000590
1 52 A 07000007 080006C0 00000790
2 00010002 00900080 0 0 0
3 00001110 00D00030 00405BC0 FE808B80 FFD00230
// Flags 0001, then a pulse with no writes
1 22 A 20000001 00101000 00000020
2 00000000 03000100 0 0 0
3 00001100 12002C00 00D05F10 FE808B80 FFD00230
2 00000000 00000000 0 0 0
3 00000000 10003000 00D05F10 FE808B80 FFD00230
// Second pulse three edges into the sequence
2 00000000 00100020 3 0 0
3 00000000 0FF02FD0 00D05F10 FE808B80 FFD00230
0 0 0 0 0 0

/* master_sync.f */
+incdir+include
design/master_sync_pkg.sv
design/mailbox_decode.sv
design/timestamp_ram.sv
design/offset_execute.sv
design/sync_result.sv
design/master_sync.sv
bench/master_sync_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module master_sync_tb \
	-f master_sync.f -o master_sync_sim

output=$(./obj_dir/master_sync_sim || true)
echo "$output"

if grep -q "Finished with no errors" <<< "$output"; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi
